//--- common/wb_if.sv
// ----------------------------------------
// Wishbone-style single master bus, one
// instance per RAM target
// ----------------------------------------

`timescale 1ns/1ps

interface wb_if;

    logic          cyc;
    logic          stb;
    logic          we;
    wb_pkg::addr_t adr;
    wb_pkg::data_t dat_w;
    wb_pkg::data_t dat_r;
    logic          ack;

    modport master (
        output cyc,
        output stb,
        output we,
        output adr,
        output dat_w,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  adr,
        input  dat_w,
        output dat_r,
        output ack
    );

endinterface

//--- common/wb_pkg.sv
// ----------------------------------------
// RAM bus widths and types for the
// Wishbone-style master and slaves
// ----------------------------------------

package wb_pkg;

    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // Word count of one RAM target
    localparam int RAM_DEPTH = 256;

endpackage

//--- common/word_stream_if.sv
// ----------------------------------------
// Word stream between the byte packers and
// the controller, valid/ready handshake
// ----------------------------------------

`timescale 1ns/1ps

interface word_stream_if;

    xfcp_pkg::word_t word;
    logic            last;
    logic            valid;
    logic            ready;

    modport source (
        output word,
        output last,
        output valid,
        input  ready
    );

    modport sink (
        input  word,
        input  last,
        input  valid,
        output ready
    );

endinterface

//--- common/xfcp_pkg.sv
// ----------------------------------------
// Packet protocol definitions shared by the
// byte packers and the command controller
// ----------------------------------------

package xfcp_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;

    // Request and response opcodes as they appear in header byte 1
    typedef enum byte_t {
        OP_READ       = 8'h10,
        OP_READ_RESP  = 8'h11,
        OP_WRITE      = 8'h12,
        OP_WRITE_RESP = 8'h13
    } opcode_e;

    // Number of RAM targets behind the controller
    localparam int PORT_COUNT = 2;

    localparam int BYTES_PER_WORD = 4;

    // Header word layout, first byte on the wire is the top byte
    localparam int HDR_PORT_MSB  = 31;
    localparam int HDR_OP_MSB    = 23;
    localparam int HDR_ADDR_MSB  = 15;
    localparam int HDR_COUNT_MSB = 7;

endpackage

//--- hw/ram/wb_ram.sv
// ----------------------------------------
// Single-port word RAM on the Wishbone-style
// bus, ack one clock after the request
// ----------------------------------------

`timescale 1ns/1ps

module wb_ram (
    input  logic clk,
    input  logic rst_i,
    wb_if.slave  bus
);

    wb_pkg::data_t mem [wb_pkg::RAM_DEPTH];
    wb_pkg::data_t dat_q;
    logic          ack_q;
    logic          req;

    // New request only while no ack is out
    assign req = bus.cyc && bus.stb && !ack_q;

    assign bus.ack   = ack_q;
    assign bus.dat_r = dat_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            if (bus.we) begin
                mem[bus.adr] <= bus.dat_w;
            end
            dat_q <= mem[bus.adr];
        end
    end

endmodule

//--- hw/xfcp/word_assembler.sv
// ----------------------------------------
// Packs request bytes into words, MSB first,
// and holds each word until it is taken
// ----------------------------------------

`timescale 1ns/1ps

module word_assembler (
    input  logic            clk,
    input  logic            rst_i,
    input  xfcp_pkg::byte_t s_tdata_i,
    input  logic            s_tvalid_i,
    output logic            s_tready_o,
    input  logic            s_tlast_i,
    word_stream_if.source   words
);

    xfcp_pkg::word_t word_q;
    logic            last_q;
    logic [1:0]      idx_q;
    logic            valid_q;
    logic            ready_q;
    logic            byte_fire;
    logic            word_done;

    assign s_tready_o  = ready_q;
    assign words.word  = word_q;
    assign words.last  = last_q;
    assign words.valid = valid_q;

    assign byte_fire = s_tvalid_i && ready_q;
    // A last byte closes the word early
    assign word_done = byte_fire &&
                       ((idx_q == 2'(xfcp_pkg::BYTES_PER_WORD - 1)) || s_tlast_i);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            ready_q <= 1'b0;
            idx_q   <= '0;
        end else if (word_done) begin
            valid_q <= 1'b1;
            ready_q <= 1'b0;
            idx_q   <= '0;
        end else if (words.valid && words.ready) begin
            valid_q <= 1'b0;
            ready_q <= 1'b1;
        end else begin
            if (byte_fire) begin
                idx_q <= idx_q + 1'b1;
            end
            if (!valid_q) begin
                ready_q <= 1'b1;
            end
        end
    end

    // Clearing on the first byte leaves unfilled low bytes at zero
    always_ff @(posedge clk) begin
        if (byte_fire) begin
            if (idx_q == '0) begin
                word_q <= '0;
            end
            word_q[8 * (xfcp_pkg::BYTES_PER_WORD - 1 - int'(idx_q)) +: 8] <= s_tdata_i;
            last_q <= s_tlast_i;
        end
    end

endmodule

//--- hw/xfcp/word_serializer.sv
// ----------------------------------------
// Sends response words as bytes, MSB first,
// and stalls with the output stream
// ----------------------------------------

`timescale 1ns/1ps

module word_serializer (
    input  logic            clk,
    input  logic            rst_i,
    word_stream_if.sink     words,
    output xfcp_pkg::byte_t m_tdata_o,
    output logic            m_tvalid_o,
    input  logic            m_tready_i,
    output logic            m_tlast_o
);

    xfcp_pkg::word_t word_q;
    logic            last_q;
    logic [1:0]      idx_q;
    logic            busy_q;
    logic            ready_q;
    logic            word_fire;
    logic            byte_fire;
    logic            final_byte;

    assign words.ready = ready_q;
    assign word_fire   = words.valid && ready_q;
    assign byte_fire   = busy_q && m_tready_i;
    assign final_byte  = idx_q == 2'(xfcp_pkg::BYTES_PER_WORD - 1);

    // Top byte of the shift register is always the next one out
    assign m_tdata_o  = word_q[$bits(xfcp_pkg::word_t)-1 -: $bits(xfcp_pkg::byte_t)];
    assign m_tvalid_o = busy_q;
    assign m_tlast_o  = busy_q && last_q && final_byte;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q  <= 1'b0;
            ready_q <= 1'b0;
            idx_q   <= '0;
        end else if (word_fire) begin
            busy_q  <= 1'b1;
            ready_q <= 1'b0;
            idx_q   <= '0;
        end else if (byte_fire) begin
            idx_q <= idx_q + 1'b1;
            if (final_byte) begin
                busy_q  <= 1'b0;
                ready_q <= 1'b1;
            end
        end else if (!busy_q) begin
            ready_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (word_fire) begin
            word_q <= words.word;
            last_q <= words.last;
        end else if (byte_fire) begin
            word_q <= word_q << $bits(xfcp_pkg::byte_t);
        end
    end

endmodule

//--- hw/xfcp/xfcp_ctrl.sv
// ----------------------------------------
// Decodes request packets word by word and
// runs the RAM bursts and the response
// ----------------------------------------

`timescale 1ns/1ps

module xfcp_ctrl (
    input  logic          clk,
    input  logic          rst_i,
    word_stream_if.sink   req,
    word_stream_if.source rsp,
    wb_if.master          bus0,
    wb_if.master          bus1
);

    typedef enum logic [2:0] {
        IDLE,
        WRITE_DATA,
        BUS_CYCLE,
        SEND_HEADER,
        SEND_DATA,
        DRAIN
    } state_e;

    state_e            state_q;
    logic              bus_req_q;
    xfcp_pkg::byte_t   port_q;
    xfcp_pkg::opcode_e op_q;
    wb_pkg::addr_t     addr_q;
    wb_pkg::addr_t     addr0_q;
    xfcp_pkg::byte_t   count_q;
    xfcp_pkg::byte_t   remain_q;
    xfcp_pkg::word_t   data_q;
    logic              last_seen_q;

    xfcp_pkg::byte_t hdr_port;
    xfcp_pkg::byte_t hdr_op;
    xfcp_pkg::byte_t hdr_addr;
    xfcp_pkg::byte_t hdr_count;
    logic            port_ok;
    logic            op_ok;
    xfcp_pkg::word_t rsp_hdr;
    logic            req_fire;
    logic            rsp_fire;
    logic            bus_ack;
    wb_pkg::data_t   bus_dat_r;

    // Header fields of the incoming word
    assign hdr_port  = req.word[xfcp_pkg::HDR_PORT_MSB -: $bits(xfcp_pkg::byte_t)];
    assign hdr_op    = req.word[xfcp_pkg::HDR_OP_MSB -: $bits(xfcp_pkg::byte_t)];
    assign hdr_addr  = req.word[xfcp_pkg::HDR_ADDR_MSB -: $bits(xfcp_pkg::byte_t)];
    assign hdr_count = req.word[xfcp_pkg::HDR_COUNT_MSB -: $bits(xfcp_pkg::byte_t)];

    assign port_ok = hdr_port < xfcp_pkg::PORT_COUNT;
    assign op_ok   = (hdr_op == xfcp_pkg::OP_READ) || (hdr_op == xfcp_pkg::OP_WRITE);

    assign req.ready = state_q inside {IDLE, WRITE_DATA, DRAIN};
    assign req_fire  = req.valid && req.ready;

    always_comb begin
        rsp_hdr = '0;
        rsp_hdr[xfcp_pkg::HDR_PORT_MSB -: $bits(xfcp_pkg::byte_t)] = port_q;
        rsp_hdr[xfcp_pkg::HDR_OP_MSB -: $bits(xfcp_pkg::byte_t)] =
            (op_q == xfcp_pkg::OP_READ) ? xfcp_pkg::OP_READ_RESP : xfcp_pkg::OP_WRITE_RESP;
        rsp_hdr[xfcp_pkg::HDR_ADDR_MSB -: $bits(xfcp_pkg::byte_t)] = addr0_q;
        rsp_hdr[xfcp_pkg::HDR_COUNT_MSB -: $bits(xfcp_pkg::byte_t)] = count_q;
    end

    // Header ends the response for writes and for empty reads
    assign rsp.valid = (state_q == SEND_HEADER) || (state_q == SEND_DATA);
    assign rsp.word  = (state_q == SEND_HEADER) ? rsp_hdr : data_q;
    assign rsp.last  = (state_q == SEND_HEADER) ?
                       ((op_q == xfcp_pkg::OP_WRITE) || (count_q == '0)) :
                       (remain_q == '0);
    assign rsp_fire  = rsp.valid && rsp.ready;

    // One shared request, steered by the port bit
    assign bus0.cyc   = bus_req_q && !port_q[0];
    assign bus0.stb   = bus_req_q && !port_q[0];
    assign bus1.cyc   = bus_req_q && port_q[0];
    assign bus1.stb   = bus_req_q && port_q[0];
    assign bus0.we    = op_q == xfcp_pkg::OP_WRITE;
    assign bus1.we    = op_q == xfcp_pkg::OP_WRITE;
    assign bus0.adr   = addr_q;
    assign bus1.adr   = addr_q;
    assign bus0.dat_w = data_q;
    assign bus1.dat_w = data_q;

    assign bus_ack   = port_q[0] ? bus1.ack : bus0.ack;
    assign bus_dat_r = port_q[0] ? bus1.dat_r : bus0.dat_r;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q   <= IDLE;
            bus_req_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_fire) begin
                        if (!port_ok || !op_ok) begin
                            state_q <= req.last ? IDLE : DRAIN;
                        end else if (hdr_op == xfcp_pkg::OP_READ) begin
                            // Read requests are exactly one word long
                            state_q <= req.last ? SEND_HEADER : DRAIN;
                        end else if (req.last) begin
                            state_q <= (hdr_count == '0) ? SEND_HEADER : IDLE;
                        end else begin
                            state_q <= (hdr_count == '0) ? DRAIN : WRITE_DATA;
                        end
                    end
                end
                WRITE_DATA: begin
                    if (req_fire) begin
                        bus_req_q <= 1'b1;
                        state_q   <= BUS_CYCLE;
                    end
                end
                BUS_CYCLE: begin
                    if (bus_ack) begin
                        bus_req_q <= 1'b0;
                        if (op_q == xfcp_pkg::OP_READ) begin
                            state_q <= SEND_DATA;
                        end else if (remain_q != '0) begin
                            // Short packet ends here without a response
                            state_q <= last_seen_q ? IDLE : WRITE_DATA;
                        end else begin
                            state_q <= last_seen_q ? SEND_HEADER : DRAIN;
                        end
                    end
                end
                SEND_HEADER, SEND_DATA: begin
                    if (rsp_fire) begin
                        if (rsp.last) begin
                            state_q <= IDLE;
                        end else begin
                            bus_req_q <= 1'b1;
                            state_q   <= BUS_CYCLE;
                        end
                    end
                end
                DRAIN: begin
                    if (req_fire && req.last) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && req_fire) begin
            port_q   <= hdr_port;
            op_q     <= xfcp_pkg::opcode_e'(hdr_op);
            addr_q   <= hdr_addr;
            addr0_q  <= hdr_addr;
            count_q  <= hdr_count;
            remain_q <= hdr_count;
        end
        if (state_q == WRITE_DATA && req_fire) begin
            data_q      <= req.word;
            last_seen_q <= req.last;
            remain_q    <= remain_q - 1'b1;
        end
        if (state_q == BUS_CYCLE && bus_ack) begin
            // Address wraps at the top of the RAM
            addr_q <= addr_q + 1'b1;
            if (op_q == xfcp_pkg::OP_READ) begin
                data_q   <= bus_dat_r;
                remain_q <= remain_q - 1'b1;
            end
        end
    end

endmodule

//--- hw/xfcp_core.sv
// ----------------------------------------
// Top level of the command core, byte
// streams in and out, two RAM targets
// ----------------------------------------

`timescale 1ns/1ps

module xfcp_core (
    input  logic            clk,
    input  logic            rst_i,

    // Request byte stream
    input  xfcp_pkg::byte_t s_tdata_i,
    input  logic            s_tvalid_i,
    output logic            s_tready_o,
    input  logic            s_tlast_i,

    // Response byte stream
    output xfcp_pkg::byte_t m_tdata_o,
    output logic            m_tvalid_o,
    input  logic            m_tready_i,
    output logic            m_tlast_o
);

    word_stream_if req_words ();
    word_stream_if rsp_words ();
    wb_if          bus0 ();
    wb_if          bus1 ();

    word_assembler word_assembler_i (
        .clk        (clk),
        .rst_i      (rst_i),
        .s_tdata_i  (s_tdata_i),
        .s_tvalid_i (s_tvalid_i),
        .s_tready_o (s_tready_o),
        .s_tlast_i  (s_tlast_i),
        .words      (req_words)
    );

    xfcp_ctrl xfcp_ctrl_i (
        .clk   (clk),
        .rst_i (rst_i),
        .req   (req_words),
        .rsp   (rsp_words),
        .bus0  (bus0),
        .bus1  (bus1)
    );

    word_serializer word_serializer_i (
        .clk        (clk),
        .rst_i      (rst_i),
        .words      (rsp_words),
        .m_tdata_o  (m_tdata_o),
        .m_tvalid_o (m_tvalid_o),
        .m_tready_i (m_tready_i),
        .m_tlast_o  (m_tlast_o)
    );

    // Port 0 and port 1 targets
    wb_ram ram0_i (
        .clk   (clk),
        .rst_i (rst_i),
        .bus   (bus0)
    );

    wb_ram ram1_i (
        .clk   (clk),
        .rst_i (rst_i),
        .bus   (bus1)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_xfcp_core -f sim.f -Mdir obj_dir

out=$(./obj_dir/Vtb_xfcp_core)
echo "$out"

echo "$out" | grep -q "^PASS: all tests$"

//--- sim.f
common/xfcp_pkg.sv
common/wb_pkg.sv
common/word_stream_if.sv
common/wb_if.sv
hw/ram/wb_ram.sv
hw/xfcp/word_assembler.sv
hw/xfcp/word_serializer.sv
hw/xfcp/xfcp_ctrl.sv
hw/xfcp_core.sv
verification/tb_xfcp_core.sv

//--- verification/tb_xfcp_core.sv
// ----------------------------------------
// Directed testbench for the command core,
// drives request packets, checks responses
// ----------------------------------------

`timescale 1ns/1ps

module tb_xfcp_core;

    localparam int MAX_CYCLES = 4000;
    localparam int RSP_LIMIT  = 300;

    typedef xfcp_pkg::byte_t byte_q_t[$];
    typedef xfcp_pkg::word_t word_q_t[$];

    logic            clk;
    logic            rst_i;
    xfcp_pkg::byte_t s_tdata_i;
    logic            s_tvalid_i;
    logic            s_tready_o;
    logic            s_tlast_i;
    xfcp_pkg::byte_t m_tdata_o;
    logic            m_tvalid_o;
    logic            m_tready_i;
    logic            m_tlast_o;

    int      seed = 32'hbc2c;
    int      cycles;
    int      value_errs;
    int      other_errs;
    word_q_t base_words;

    xfcp_core xfcp_core_i (
        .clk        (clk),
        .rst_i      (rst_i),
        .s_tdata_i  (s_tdata_i),
        .s_tvalid_i (s_tvalid_i),
        .s_tready_o (s_tready_o),
        .s_tlast_i  (s_tlast_i),
        .m_tdata_o  (m_tdata_o),
        .m_tvalid_o (m_tvalid_o),
        .m_tready_i (m_tready_i),
        .m_tlast_o  (m_tlast_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_byte(input string name, input xfcp_pkg::byte_t exp,
                              input xfcp_pkg::byte_t act);
        if (exp !== act) begin
            $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_opcode(input string name, input xfcp_pkg::opcode_e exp,
                                input xfcp_pkg::opcode_e act);
        if (exp !== act) begin
            $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("Fail at %0t: %s expected %0d got %0d", $time, name, exp, act);
            value_errs++;
        end
    endtask

    // Header bytes then each word MSB first, same layout for requests and responses
    function automatic byte_q_t packet_bytes(input xfcp_pkg::byte_t port,
                                             input xfcp_pkg::byte_t op,
                                             input xfcp_pkg::byte_t addr,
                                             input xfcp_pkg::byte_t count,
                                             input word_q_t words);
        byte_q_t q;
        q.push_back(port);
        q.push_back(op);
        q.push_back(addr);
        q.push_back(count);
        foreach (words[i]) begin
            for (int b = 3; b >= 0; b--) begin
                q.push_back(words[i][8 * b +: 8]);
            end
        end
        return q;
    endfunction

    // Called and returns 2 ns after a rising edge
    task automatic send_packet(input byte_q_t bytes, input bit gaps);
        int i;
        bit fire;
        i = 0;
        while (i < bytes.size()) begin
            // A stalled byte stays valid until it is taken
            if (!s_tvalid_i) begin
                s_tvalid_i = !(gaps && ($random(seed) & 1));
            end
            s_tdata_i = bytes[i];
            s_tlast_i = (i == bytes.size() - 1);
            @(negedge clk);
            fire = s_tvalid_i && s_tready_o;
            @(posedge clk);
            #2;
            if (fire) begin
                i++;
                s_tvalid_i = 1'b0;
            end
        end
        s_tvalid_i = 1'b0;
        s_tlast_i  = 1'b0;
    endtask

    task automatic collect_response(output byte_q_t got, input bit gaps);
        int waited;
        bit done;
        got    = {};
        waited = 0;
        done   = 1'b0;
        while (!done && waited < RSP_LIMIT) begin
            m_tready_i = !(gaps && ($random(seed) & 1));
            @(negedge clk);
            if (m_tvalid_o && m_tready_i) begin
                got.push_back(m_tdata_o);
                done = m_tlast_o;
            end
            @(posedge clk);
            #2;
            waited++;
        end
        m_tready_i = 1'b0;
        if (!done) begin
            $display("Error at %0t: no complete response within %0d cycles, %0d bytes seen",
                     $time, RSP_LIMIT, got.size());
            other_errs++;
        end
    endtask

    task automatic expect_quiet(input int n);
        int seen;
        seen       = 0;
        m_tready_i = 1'b1;
        repeat (n) begin
            @(negedge clk);
            if (m_tvalid_o) begin
                seen++;
            end
            @(posedge clk);
            #2;
        end
        m_tready_i = 1'b0;
        if (seen != 0) begin
            $display("Error at %0t: %0d response bytes appeared for dropped packets",
                     $time, seen);
            other_errs++;
        end
    endtask

    task automatic exchange(input byte_q_t req, input byte_q_t exp, input bit gaps);
        byte_q_t got;
        fork
            send_packet(req, gaps);
            collect_response(got, gaps);
        join
        // Length check also fixes where m_tlast_o fell
        check_count("response length", exp.size(), got.size());
        for (int i = 0; i < exp.size() && i < got.size(); i++) begin
            if (i == 1) begin
                check_opcode("m_tdata_o opcode", xfcp_pkg::opcode_e'(exp[i]),
                             xfcp_pkg::opcode_e'(got[i]));
            end else begin
                check_byte($sformatf("m_tdata_o byte %0d", i), exp[i], got[i]);
            end
        end
    endtask

    task automatic write_words(input xfcp_pkg::byte_t port, input xfcp_pkg::byte_t addr,
                               input word_q_t words, input bit gaps);
        word_q_t none;
        exchange(packet_bytes(port, xfcp_pkg::OP_WRITE, addr, 8'(words.size()), words),
                 packet_bytes(port, xfcp_pkg::OP_WRITE_RESP, addr, 8'(words.size()), none),
                 gaps);
    endtask

    task automatic read_words(input xfcp_pkg::byte_t port, input xfcp_pkg::byte_t addr,
                              input word_q_t exp_words, input bit gaps);
        word_q_t none;
        exchange(packet_bytes(port, xfcp_pkg::OP_READ, addr, 8'(exp_words.size()), none),
                 packet_bytes(port, xfcp_pkg::OP_READ_RESP, addr, 8'(exp_words.size()),
                              exp_words),
                 gaps);
    endtask

    task automatic write_then_read();
        write_words(8'd0, 8'h10, base_words, 1'b0);
        read_words(8'd0, 8'h10, base_words, 1'b0);
    endtask

    task automatic port_independence();
        word_q_t w0;
        word_q_t w1;
        w0.push_back(32'h0123_4567);
        w1.push_back(32'h89AB_CDEF);
        write_words(8'd0, 8'h20, w0, 1'b0);
        write_words(8'd1, 8'h20, w1, 1'b0);
        read_words(8'd0, 8'h20, w0, 1'b0);
        read_words(8'd1, 8'h20, w1, 1'b0);
    endtask

    task automatic address_wrap();
        word_q_t w;
        word_q_t third;
        word_q_t fourth;
        repeat (4) begin
            w.push_back($random(seed));
        end
        write_words(8'd0, 8'hFE, w, 1'b0);
        // Third and fourth words land at 0x00 and 0x01
        third.push_back(w[2]);
        fourth.push_back(w[3]);
        read_words(8'd0, 8'h00, third, 1'b0);
        read_words(8'd0, 8'h01, fourth, 1'b0);
    endtask

    task automatic dropped_packets();
        byte_q_t short_pkt;
        word_q_t one;
        word_q_t none;
        send_packet(packet_bytes(8'd2, xfcp_pkg::OP_READ, 8'h10, 8'd1, none), 1'b0);
        send_packet(packet_bytes(8'd0, 8'h55, 8'h10, 8'd1, none), 1'b0);
        // Truncated header
        short_pkt.push_back(8'h01);
        short_pkt.push_back(8'h00);
        short_pkt.push_back(8'h20);
        send_packet(short_pkt, 1'b0);
        // Count says two words, last comes on the first
        one.push_back(32'hCAFE_F00D);
        send_packet(packet_bytes(8'd1, xfcp_pkg::OP_WRITE, 8'h40, 8'd2, one), 1'b0);
        expect_quiet(40);
        read_words(8'd0, 8'h10, base_words, 1'b0);
    endtask

    task automatic back_pressure();
        word_q_t w;
        // New words, so the read back shows what this write stored
        repeat (3) begin
            w.push_back($random(seed));
        end
        write_words(8'd0, 8'h10, w, 1'b1);
        read_words(8'd0, 8'h10, w, 1'b1);
    endtask

    task automatic zero_count();
        word_q_t none;
        read_words(8'd1, 8'h33, none, 1'b0);
    endtask

    // Run limit
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run stopped after %0d cycles", cycles);
        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rst_i      = 1'b1;
        s_tdata_i  = '0;
        s_tvalid_i = 1'b0;
        s_tlast_i  = 1'b0;
        m_tready_i = 1'b0;
        value_errs = 0;
        other_errs = 0;
        base_words.push_back(32'h1122_3344);
        base_words.push_back(32'hA5A5_0F0F);
        base_words.push_back(32'hDEAD_BEEF);

        repeat (10) @(posedge clk);
        #2;
        if (s_tready_o !== 1'b0 || m_tvalid_o !== 1'b0 || m_tlast_o !== 1'b0) begin
            $display("Error at %0t: stream outputs are not low in reset", $time);
            other_errs++;
        end
        rst_i = 1'b0;

        write_then_read();
        port_independence();
        address_wrap();
        dropped_packets();
        back_pressure();
        zero_count();

        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
